// ==== src/pipeline_consts.svh ====
// pipeline-wide constants
// data and line widths, lane count, register and tag index widths
// nop encoding and the zero register index

`ifndef PIPELINE_CONSTS_SVH
`define PIPELINE_CONSTS_SVH

//////////////////////////////
// widths
//////////////////////////////
`define XLEN      32 // data and address width
`define N_LANES   3  // superscalar width
`define REG_IDX_W 5  // architectural register index
`define ROB_TAG_W 4  // reorder buffer tag
`define LINE_W    64 // memory line

//////////////////////////////
// encodings
//////////////////////////////
`define NOP_INST  32'h0000_0013 // addi x0, x0, 0
`define ZERO_REG  5'd0          // x0, writes are discarded

`endif

// ==== src/pipeline_pkg.sv ====
// shared pipeline types
// memory bus command, pipeline status
// issue packet and the lane array of issue packets

`default_nettype none

`include "pipeline_consts.svh"

package pipeline_pkg;

    // command levels on the memory bus
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0, // idle
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_e;

    // pipeline status seen by the outside world
    typedef enum logic [3:0] {
        NO_ERROR      = 4'h0,
        HALTED_ON_WFI = 4'h1  // a wfi retired
    } error_status_e;

    //////////////////////////////
    // issue / execute packet
    //////////////////////////////
    typedef struct packed {
        logic [`ROB_TAG_W-1:0] tag;          // rob entry
        logic [31:0]           inst;
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      npc;          // pc + 4 or predicted target
        logic [`XLEN-1:0]      rs1_value;
        logic [`XLEN-1:0]      rs2_value;
        logic [`REG_IDX_W-1:0] dest_reg_idx;
        logic                  valid;
    } issue_packet_t;

    // one packet per lane, lane 0 oldest
    typedef issue_packet_t [`N_LANES-1:0] issue_lanes_t;

endpackage

`default_nettype wire

// ==== src/mem_req_if.sv ====
// memory request bundle for one requester
// command, address, write data and the blocked level back from the arbiter

`timescale 1ns/1ps
`default_nettype none

`include "pipeline_consts.svh"

interface mem_req_if;
    import pipeline_pkg::*;

    bus_command_e     command; // BUS_NONE means no request this cycle
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] data;    // store data, low word of the line
    logic             blocked; // request lost the bus this cycle

    modport requester (output command, addr, data, input blocked);
    modport arbiter   (input command, addr, data, output blocked);

endinterface

`default_nettype wire

// ==== src/mem_bus_arbiter.sv ====
// arbiter for the single memory bus
// data requests win over instruction fetch
// store data zero-extended to the memory line

`timescale 1ns/1ps
`default_nettype none

`include "pipeline_consts.svh"

module mem_bus_arbiter (
    input  logic                       clock,
    input  logic                       reset,
    mem_req_if.arbiter                 dmem,
    mem_req_if.arbiter                 imem,
    output pipeline_pkg::bus_command_e proc2mem_command,
    output logic [`XLEN-1:0]           proc2mem_addr,
    output logic [`LINE_W-1:0]         proc2mem_data
);
    import pipeline_pkg::*;

    logic dmem_active; // data side wants the bus
    logic imem_active;

    assign dmem_active = (dmem.command != BUS_NONE);
    assign imem_active = (imem.command != BUS_NONE);

    //////////////////////////////
    // bus select
    //////////////////////////////
    always_comb begin
        if (dmem_active) begin
            proc2mem_command = dmem.command;
            proc2mem_addr    = dmem.addr;
        end else begin
            proc2mem_command = imem.command; // fetch gets the idle bus
            proc2mem_addr    = imem.addr;
        end
        // only the data side ever writes
        proc2mem_data = {{(`LINE_W-`XLEN){1'b0}}, dmem.data};
    end

    assign dmem.blocked = 1'b0;                       // data side never waits
    assign imem.blocked = dmem_active && imem_active; // fetch must hold and retry

    // a load or store is never dropped by the bus
    assert property (@(posedge clock) disable iff (reset)
        dmem_active |-> (proc2mem_command == dmem.command));

    // a fetch is only held off while the data side owns the bus
    assert property (@(posedge clock) disable iff (reset)
        imem.blocked |-> (proc2mem_addr == dmem.addr));

endmodule

`default_nettype wire

// ==== src/issue_reg.sv ====
// issue / execute pipeline register for all lanes
// resets every lane to a nop packet

`timescale 1ns/1ps
`default_nettype none

`include "pipeline_consts.svh"

module issue_reg (
    input  logic                       clock,
    input  logic                       reset,
    input  pipeline_pkg::issue_lanes_t issue_in,
    output pipeline_pkg::issue_lanes_t issue_out
);
    import pipeline_pkg::*;

    // bubble that sits in a lane after reset
    localparam issue_packet_t NOP_PACKET = '{
        tag:          '0,
        inst:         `NOP_INST,
        pc:           '0,
        npc:          '0,
        rs1_value:    '0,
        rs2_value:    '0,
        dest_reg_idx: `ZERO_REG,
        valid:        1'b0
    };

    //////////////////////////////
    // lane registers
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `N_LANES; i++) begin
                issue_out[i] <= NOP_PACKET;
            end
        end else begin
            issue_out <= issue_in; // no flush on squash, execute drops stale tags
        end
    end

    // a valid packet leaving the register is the one issued last cycle
    for (genvar i = 0; i < `N_LANES; i++) begin : g_tag_chk
        assert property (@(posedge clock) disable iff (reset)
            issue_out[i].valid |-> (issue_out[i].tag == $past(issue_in[i].tag)));
    end

endmodule

`default_nettype wire

// ==== src/commit_unit.sv ====
// retire status bundle from commit to control
// commit unit: register write port, completed counts, gated next pcs
// and the retire status for control

`timescale 1ns/1ps
`default_nettype none

`include "pipeline_consts.svh"

interface retire_if;
    logic [`N_LANES-1:0] lane_valid;
    logic [`N_LANES-1:0] lane_halt;
    logic                squash_flag; // redirect fetch
    logic [`XLEN-1:0]    squash_pc;
    logic [`XLEN-1:0]    retire_npc;  // npc of youngest retiring lane
    logic                halt_seen;   // some valid lane halted

    modport source (output lane_valid, lane_halt, squash_flag, squash_pc, retire_npc, halt_seen);
    modport sink   (input lane_valid, lane_halt, squash_flag, squash_pc, retire_npc, halt_seen);
endinterface

module commit_unit (
    input  logic [`N_LANES-1:0]                retire_valid,
    input  logic [`N_LANES-1:0][`REG_IDX_W-1:0] retire_reg_idx,
    input  logic [`N_LANES-1:0][`XLEN-1:0]     retire_value,
    input  logic [`N_LANES-1:0][`XLEN-1:0]     retire_npc,
    input  logic [`N_LANES-1:0]                retire_halt,
    input  logic                               squash_flag,
    input  logic [`XLEN-1:0]                   squash_pc,
    output logic [`N_LANES-1:0][3:0]           completed_insts,
    output logic [`N_LANES-1:0]                commit_wr_en,
    output logic [`N_LANES-1:0][`REG_IDX_W-1:0] commit_wr_idx,
    output logic [`N_LANES-1:0][`XLEN-1:0]     commit_wr_data,
    output logic [`N_LANES-1:0][`XLEN-1:0]     commit_npc,
    retire_if.source                           status
);

    //////////////////////////////
    // per-lane commit outputs
    //////////////////////////////
    always_comb begin
        for (int i = 0; i < `N_LANES; i++) begin
            completed_insts[i] = {3'b0, retire_valid[i]}; // one inst per valid lane
            commit_wr_en[i]    = retire_valid[i] && (retire_reg_idx[i] != `ZERO_REG);
            commit_wr_idx[i]   = retire_reg_idx[i];
            commit_wr_data[i]  = retire_value[i];
            commit_npc[i]      = retire_valid[i] ? retire_npc[i] : '0;
        end
    end

    //////////////////////////////
    // retire status to control
    //////////////////////////////
    always_comb begin
        status.retire_npc = '0;
        for (int i = 0; i < `N_LANES; i++) begin
            if (retire_valid[i]) begin
                status.retire_npc = retire_npc[i]; // later lanes override
            end
        end
    end

    assign status.lane_valid  = retire_valid;
    assign status.lane_halt   = retire_halt;
    assign status.squash_flag = squash_flag;
    assign status.squash_pc   = squash_pc;
    assign status.halt_seen   = |(retire_valid & retire_halt); // halt on invalid lane ignored

    // a register write is always counted as a completed inst
    always_comb begin
        for (int i = 0; i < `N_LANES; i++) begin
            assert (!commit_wr_en[i] || (completed_insts[i] == 4'd1));
        end
    end

endmodule

`default_nettype wire

// ==== src/pipeline_ctrl.sv ====
// pipeline control
// registered next-fetch pc, squash redirect over the predictor
// pipeline status from the retire bundle

`timescale 1ns/1ps
`default_nettype none

`include "pipeline_consts.svh"

module pipeline_ctrl (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [`XLEN-1:0]            bp_npc,
    retire_if.sink                      status,
    output logic [`XLEN-1:0]            fetch_pc,
    output pipeline_pkg::error_status_e error_status
);
    import pipeline_pkg::*;

    //////////////////////////////
    // next fetch pc
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_pc <= '0;
        end else if (status.squash_flag) begin
            fetch_pc <= status.squash_pc; // mispredict or exception wins
        end else begin
            fetch_pc <= bp_npc;
        end
    end

    assign error_status = status.halt_seen ? HALTED_ON_WFI : NO_ERROR;

    //////////////////////////////
    // checks
    //////////////////////////////
    // redirect lands one cycle later
    assert property (@(posedge clock) disable iff (reset)
        status.squash_flag |=> (fetch_pc == $past(status.squash_pc)));

    // status only when a valid lane actually halted
    assert property (@(posedge clock) disable iff (reset)
        (error_status == HALTED_ON_WFI) == |(status.lane_valid & status.lane_halt));

    // nothing retiring, so no retire npc either
    assert property (@(posedge clock) disable iff (reset)
        !(|status.lane_valid) |-> (status.retire_npc == '0));

endmodule

`default_nettype wire

// ==== src/pipeline.sv ====
// top level of the pipeline glue
// memory bus arbitration, next-fetch pc, issue/execute register
// and commit outputs

`timescale 1ns/1ps
`default_nettype none

`include "pipeline_consts.svh"

module pipeline (
    input  logic                                clock,
    input  logic                                reset,
    // memory requesters
    input  pipeline_pkg::bus_command_e          dmem_command,
    input  logic [`XLEN-1:0]                    dmem_addr,
    input  logic [`XLEN-1:0]                    dmem_data,
    input  pipeline_pkg::bus_command_e          imem_command,
    input  logic [`XLEN-1:0]                    imem_addr,
    // fetch and issue
    input  logic [`XLEN-1:0]                    bp_npc,
    input  pipeline_pkg::issue_lanes_t          issue_in,
    // retire
    input  logic [`N_LANES-1:0]                 retire_valid,
    input  logic [`N_LANES-1:0][`REG_IDX_W-1:0] retire_reg_idx,
    input  logic [`N_LANES-1:0][`XLEN-1:0]      retire_value,
    input  logic [`N_LANES-1:0][`XLEN-1:0]      retire_npc,
    input  logic [`N_LANES-1:0]                 retire_halt,
    input  logic                                squash_flag,
    input  logic [`XLEN-1:0]                    squash_pc,

    output logic                                imem_blocked,
    output pipeline_pkg::bus_command_e          proc2mem_command,
    output logic [`XLEN-1:0]                    proc2mem_addr,
    output logic [`LINE_W-1:0]                  proc2mem_data,
    output logic [`XLEN-1:0]                    fetch_pc,
    output pipeline_pkg::issue_lanes_t          issue_out,
    output logic [`N_LANES-1:0][3:0]            completed_insts,
    output logic [`N_LANES-1:0]                 commit_wr_en,
    output logic [`N_LANES-1:0][`REG_IDX_W-1:0] commit_wr_idx,
    output logic [`N_LANES-1:0][`XLEN-1:0]      commit_wr_data,
    output logic [`N_LANES-1:0][`XLEN-1:0]      commit_npc,
    output pipeline_pkg::error_status_e         error_status
);

    //////////////////////////////
    // memory bus
    //////////////////////////////
    mem_req_if dmem_req ();
    mem_req_if imem_req ();

    assign dmem_req.command = dmem_command;
    assign dmem_req.addr    = dmem_addr;
    assign dmem_req.data    = dmem_data;
    assign imem_req.command = imem_command;
    assign imem_req.addr    = imem_addr;
    assign imem_req.data    = '0;  // fetch only reads
    assign imem_blocked     = imem_req.blocked;

    mem_bus_arbiter mem_bus_arbiter_inst (
        .clock            (clock),
        .reset            (reset),
        .dmem             (dmem_req.arbiter),
        .imem             (imem_req.arbiter),
        .proc2mem_command (proc2mem_command),
        .proc2mem_addr    (proc2mem_addr),
        .proc2mem_data    (proc2mem_data)
    );

    //////////////////////////////
    // issue / execute boundary
    //////////////////////////////
    issue_reg issue_reg_inst (
        .clock     (clock),
        .reset     (reset),
        .issue_in  (issue_in),
        .issue_out (issue_out)
    );

    //////////////////////////////
    // commit and control
    //////////////////////////////
    retire_if retire_bus ();

    commit_unit commit_unit_inst (
        .retire_valid    (retire_valid),
        .retire_reg_idx  (retire_reg_idx),
        .retire_value    (retire_value),
        .retire_npc      (retire_npc),
        .retire_halt     (retire_halt),
        .squash_flag     (squash_flag),
        .squash_pc       (squash_pc),
        .completed_insts (completed_insts),
        .commit_wr_en    (commit_wr_en),
        .commit_wr_idx   (commit_wr_idx),
        .commit_wr_data  (commit_wr_data),
        .commit_npc      (commit_npc),
        .status          (retire_bus.source)
    );

    pipeline_ctrl pipeline_ctrl_inst (
        .clock        (clock),
        .reset        (reset),
        .bp_npc       (bp_npc),
        .status       (retire_bus.sink),
        .fetch_pc     (fetch_pc),
        .error_status (error_status)
    );

endmodule

`default_nettype wire

// ==== test/pipeline_tb.sv ====
// testbench for the pipeline glue logic
// lfsr stimulus, reference model and compare tasks
// reset wait and main loop each bounded by a timeout

`timescale 1ns/1ps
`default_nettype none

`include "pipeline_consts.svh"

module pipeline_tb;
    import pipeline_pkg::*;

    localparam int N_CYCLES      = 2000;
    localparam int RESET_TIMEOUT = 20;          // negedges
    localparam int LOOP_TIMEOUT  = N_CYCLES + 10;

    // all commit outputs of one cycle
    typedef struct packed {
        logic [`N_LANES-1:0][3:0]            completed;
        logic [`N_LANES-1:0]                 wr_en;
        logic [`N_LANES-1:0][`REG_IDX_W-1:0] wr_idx;
        logic [`N_LANES-1:0][`XLEN-1:0]      wr_data;
        logic [`N_LANES-1:0][`XLEN-1:0]      npc;
    } commit_t;

    logic clock;
    logic reset;
    bus_command_e                        dmem_command;
    bus_command_e                        imem_command;
    logic [`XLEN-1:0]                    dmem_addr, dmem_data, imem_addr, bp_npc, squash_pc;
    issue_lanes_t                        issue_in;
    logic [`N_LANES-1:0]                 retire_valid, retire_halt;
    logic [`N_LANES-1:0][`REG_IDX_W-1:0] retire_reg_idx;
    logic [`N_LANES-1:0][`XLEN-1:0]      retire_value, retire_npc;
    logic                                squash_flag;

    logic                                imem_blocked;
    bus_command_e                        proc2mem_command;
    logic [`XLEN-1:0]                    proc2mem_addr, fetch_pc;
    logic [`LINE_W-1:0]                  proc2mem_data;
    issue_lanes_t                        issue_out;
    logic [`N_LANES-1:0][3:0]            completed_insts;
    logic [`N_LANES-1:0]                 commit_wr_en;
    logic [`N_LANES-1:0][`REG_IDX_W-1:0] commit_wr_idx;
    logic [`N_LANES-1:0][`XLEN-1:0]      commit_wr_data, commit_npc;
    error_status_e                       error_status;

    logic [31:0]      lfsr_state;
    logic [`XLEN-1:0] exp_pc;    // registered model state
    issue_lanes_t     exp_issue;

    pipeline pipeline_inst (.*);

    //////////////////////////////
    // clock and reset
    //////////////////////////////
    initial clock = 1'b0;
    always #50 clock = ~clock;

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clock);
        #1 reset = 1'b0;
    end

    //////////////////////////////
    // random source
    //////////////////////////////
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]}; // one step per bit
        end
    endtask

    function automatic bus_command_e pick_command(input logic [1:0] r);
        case (r)
            2'd1:    return BUS_LOAD;
            2'd2:    return BUS_STORE;
            default: return BUS_NONE; // idle twice as often
        endcase
    endfunction

    task automatic drive_random();
        logic [31:0] r;
        take_bits(2, r);
        dmem_command = pick_command(r[1:0]);
        take_bits(2, r);
        imem_command = pick_command(r[1:0]);
        take_bits(`XLEN, r);
        dmem_addr = r;
        take_bits(`XLEN, r);
        dmem_data = r;
        take_bits(`XLEN, r);
        imem_addr = r;
        take_bits(`XLEN, r);
        bp_npc = r;
        take_bits(`XLEN, r);
        squash_pc = r;
        take_bits(2, r);
        squash_flag = (r[1:0] == 2'd0); // redirect about a quarter of cycles
        for (int i = 0; i < `N_LANES; i++) begin
            take_bits(`ROB_TAG_W, r);
            issue_in[i].tag = r[`ROB_TAG_W-1:0];
            take_bits(32, r);
            issue_in[i].inst = r;
            take_bits(`XLEN, r);
            issue_in[i].pc = r;
            take_bits(`XLEN, r);
            issue_in[i].npc = r;
            take_bits(`XLEN, r);
            issue_in[i].rs1_value = r;
            take_bits(`XLEN, r);
            issue_in[i].rs2_value = r;
            take_bits(`REG_IDX_W + 1, r);
            issue_in[i].dest_reg_idx = r[`REG_IDX_W:1];
            issue_in[i].valid = r[0];
            take_bits(2, r);
            retire_valid[i] = r[0];
            retire_halt[i]  = r[1];     // also set on invalid lanes
            take_bits(2 + `REG_IDX_W, r);
            // x0 forced now and then so dropped writes show up
            retire_reg_idx[i] = (r[1:0] == 2'd0) ? `ZERO_REG : r[`REG_IDX_W+1:2];
            take_bits(`XLEN, r);
            retire_value[i] = r;
            take_bits(`XLEN, r);
            retire_npc[i] = r;
        end
    endtask

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "testbench stopped at first failure");
    endtask

    task automatic check_bus(input bus_command_e got_cmd, input bus_command_e exp_cmd,
                             input logic [`XLEN-1:0] got_addr, input logic [`XLEN-1:0] exp_addr,
                             input logic [`LINE_W-1:0] got_line,
                             input logic [`LINE_W-1:0] exp_line,
                             input logic got_blocked, input logic exp_blocked);
        if (got_cmd !== exp_cmd)
            report_failure($sformatf("error proc2mem_command: got 0x%h expected 0x%h",
                                     got_cmd, exp_cmd));
        if (got_addr !== exp_addr)
            report_failure($sformatf("error proc2mem_addr: got 0x%h expected 0x%h",
                                     got_addr, exp_addr));
        if (got_line !== exp_line)
            report_failure($sformatf("error proc2mem_data: got 0x%h expected 0x%h",
                                     got_line, exp_line));
        if (got_blocked !== exp_blocked)
            report_failure($sformatf("error imem_blocked: got 0x%h expected 0x%h",
                                     got_blocked, exp_blocked));
    endtask

    task automatic check_issue(input issue_lanes_t got, input issue_lanes_t exp);
        if (got !== exp)
            report_failure($sformatf("error issue_out: got 0x%h expected 0x%h", got, exp));
    endtask

    task automatic check_commit(input commit_t got, input commit_t exp);
        if (got.completed !== exp.completed)
            report_failure($sformatf("error completed_insts: got 0x%h expected 0x%h",
                                     got.completed, exp.completed));
        if (got.wr_en !== exp.wr_en)
            report_failure($sformatf("error commit_wr_en: got 0x%h expected 0x%h",
                                     got.wr_en, exp.wr_en));
        if (got.wr_idx !== exp.wr_idx)
            report_failure($sformatf("error commit_wr_idx: got 0x%h expected 0x%h",
                                     got.wr_idx, exp.wr_idx));
        if (got.wr_data !== exp.wr_data)
            report_failure($sformatf("error commit_wr_data: got 0x%h expected 0x%h",
                                     got.wr_data, exp.wr_data));
        if (got.npc !== exp.npc)
            report_failure($sformatf("error commit_npc: got 0x%h expected 0x%h",
                                     got.npc, exp.npc));
    endtask

    task automatic check_pc(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
        if (got !== exp)
            report_failure($sformatf("error fetch_pc: got 0x%h expected 0x%h", got, exp));
    endtask

    task automatic check_status(input error_status_e got, input error_status_e exp);
        if (got !== exp)
            report_failure($sformatf("error error_status: got 0x%h expected 0x%h", got, exp));
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////
    task automatic check_outputs();
        bus_command_e     exp_cmd;
        logic [`XLEN-1:0] exp_addr;
        commit_t          got_commit;
        commit_t          exp_commit;
        logic             halt_seen;
        if (dmem_command != BUS_NONE) begin // data side first
            exp_cmd  = dmem_command;
            exp_addr = dmem_addr;
        end else begin
            exp_cmd  = imem_command;
            exp_addr = imem_addr;
        end
        check_bus(proc2mem_command, exp_cmd, proc2mem_addr, exp_addr,
                  proc2mem_data, {{(`LINE_W-`XLEN){1'b0}}, dmem_data},
                  imem_blocked, (dmem_command != BUS_NONE) && (imem_command != BUS_NONE));
        check_issue(issue_out, exp_issue);
        check_pc(fetch_pc, exp_pc);
        halt_seen = 1'b0;
        for (int i = 0; i < `N_LANES; i++) begin
            exp_commit.completed[i] = retire_valid[i] ? 4'd1 : 4'd0;
            exp_commit.wr_en[i]     = retire_valid[i] && (retire_reg_idx[i] != 5'd0);
            exp_commit.wr_idx[i]    = retire_reg_idx[i];
            exp_commit.wr_data[i]   = retire_value[i];
            exp_commit.npc[i]       = retire_valid[i] ? retire_npc[i] : '0;
            if (retire_valid[i] && retire_halt[i]) halt_seen = 1'b1;
        end
        got_commit = '{completed_insts, commit_wr_en, commit_wr_idx, commit_wr_data, commit_npc};
        check_commit(got_commit, exp_commit);
        check_status(error_status, halt_seen ? HALTED_ON_WFI : NO_ERROR);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        int wait_cycles;
        int loop_cycles;
        lfsr_state   = 32'd94068;
        dmem_command = BUS_NONE;
        imem_command = BUS_NONE;
        dmem_addr    = '0;
        dmem_data    = '0;
        imem_addr    = '0;
        bp_npc       = '0;
        squash_pc    = '0;
        squash_flag  = 1'b0;
        issue_in     = '0;
        retire_valid = '0;
        retire_halt  = '0;
        retire_reg_idx = '0;
        retire_value = '0;
        retire_npc   = '0;

        wait_cycles = 0;
        while (reset !== 1'b0) begin
            @(negedge clock);
            wait_cycles++;
            if (wait_cycles > RESET_TIMEOUT) report_failure("reset was never released");
        end

        // registers still hold their reset values here
        exp_pc = '0;
        for (int i = 0; i < `N_LANES; i++) begin
            exp_issue[i]              = '0;
            exp_issue[i].inst         = `NOP_INST;
            exp_issue[i].dest_reg_idx = `ZERO_REG;
        end
        check_outputs();

        loop_cycles = 0;
        while (loop_cycles < N_CYCLES) begin
            @(posedge clock);
            exp_pc    = squash_flag ? squash_pc : bp_npc; // inputs held across the edge
            exp_issue = issue_in;
            #1;
            drive_random();
            @(negedge clock);   // outputs settled
            check_outputs();
            loop_cycles++;
            if ($time > LOOP_TIMEOUT * 100 + 1000) report_failure("main loop ran out of time");
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+src
src/pipeline_pkg.sv
src/mem_req_if.sv
src/mem_bus_arbiter.sv
src/issue_reg.sv
src/commit_unit.sv
src/pipeline_ctrl.sv
src/pipeline.sv
test/pipeline_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module pipeline_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vpipeline_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
